/* logic/copPkg.sv */
// Shared widths, register map, bus request and engine state for the dot-product coprocessor
package copPkg;

  // Register file geometry
  localparam int unsigned pairCount = 10;
  localparam int unsigned regCount  = 22;
  localparam int unsigned regStride = 4;

  // Register file slots holding the scalar operands
  localparam int unsigned biasIdx  = 20;
  localparam int unsigned shiftIdx = 21;

  typedef logic        [8:0]          addrT;
  typedef logic signed [15:0]         dataT;
  typedef logic        [31:0]         busWordT;
  typedef logic signed [39:0]         accT;
  typedef logic        [regCount-1:0] enablesT;
  typedef logic        [3:0]          pairIdxT;

  // Bus addresses
  localparam addrT firstRegAddr = 9'h00C;
  localparam addrT startAddr    = 9'h08C;
  localparam addrT statusAddr   = 9'h090;
  localparam addrT resultAddr   = 9'h094;

  // One bus cycle, strobes plus address and write data
  typedef struct packed {
    logic write;
    logic read;
    addrT address;
    dataT data;
  } busReqT;

  // All operand registers side by side, word k at slice k
  typedef dataT [regCount-1:0] regFileT;

  typedef enum logic [1:0] {
    idle,
    accumulate,
    finish
  } engStateT;

endpackage

/* logic/decoEscrituraRegistros.sv */
// Combinational write decoder, turns a bus write into one register enable or the start enable
`timescale 1ns/1ps

module decoEscrituraRegistros (
  input  logic            write,
  input  copPkg::addrT    address,
  output copPkg::enablesT enableRegister,
  output logic            enableStart
);

  copPkg::enablesT addrHit;

  // Register k sits at firstRegAddr + k * regStride
  always_comb begin
    for (int k = 0; k < copPkg::regCount; k++) begin
      addrHit[k] = (address == copPkg::addrT'(copPkg::firstRegAddr + k * copPkg::regStride));
    end
  end

  // Nothing is enabled without the write strobe
  assign enableRegister = write ? addrHit : '0;

  // Start lies outside the register window so it cannot overlap an enable
  assign enableStart = write && (address == copPkg::startAddr);

endmodule

/* logic/registerBank.sv */
// Operand register file, each word loaded from the bus data when its enable is high
`timescale 1ns/1ps

module registerBank (
  input  logic            clk,
  input  logic            rst,
  input  copPkg::enablesT enableRegister,
  input  copPkg::dataT    data,
  output copPkg::regFileT regFile
);

  // At most one enable is set per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      regFile <= '0;
    end else begin
      for (int k = 0; k < copPkg::regCount; k++) begin
        if (enableRegister[k]) begin
          regFile[k] <= data;
        end
      end
    end
  end

endmodule

/* logic/dotProductEngine.sv */
// Multiply-accumulate engine, one operand pair per cycle, then bias-adjusted and shifted result
`timescale 1ns/1ps

module dotProductEngine (
  input  logic             clk,
  input  logic             rst,
  input  logic             enableStart,
  input  copPkg::regFileT  regFile,
  output logic             busy,
  output logic             done,
  output copPkg::busWordT  result
);

  copPkg::engStateT   state;
  copPkg::pairIdxT    pairIdx;
  copPkg::accT        acc;
  copPkg::accT        shifted;
  copPkg::dataT       opA;
  copPkg::dataT       opB;
  copPkg::dataT       bias;
  logic signed [31:0] product;
  logic        [4:0]  shiftAmount;
  logic               startAccepted;

  // Operands come straight from the register file
  assign opA         = regFile[pairIdx];
  assign opB         = regFile[pairIdx + copPkg::pairCount];
  assign bias        = regFile[copPkg::biasIdx];
  assign shiftAmount = regFile[copPkg::shiftIdx][4:0];

  // Full 32-bit signed product
  assign product = opA * opB;

  // Arithmetic shift keeps the sign of the sum
  assign shifted = acc >>> shiftAmount;

  // Start only counts while idle
  assign startAccepted = (state == copPkg::idle) && enableStart;

  assign busy = (state == copPkg::accumulate);
  assign done = (state == copPkg::finish);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= copPkg::idle;
      pairIdx <= '0;
      result  <= '0;
    end else begin
      case (state)
        copPkg::idle: begin
          if (enableStart) begin
            state   <= copPkg::accumulate;
            pairIdx <= '0;
          end
        end
        copPkg::accumulate: begin
          pairIdx <= pairIdx + 1'b1;
          // Last pair goes in this cycle
          if (pairIdx == copPkg::pairIdxT'(copPkg::pairCount - 1)) begin
            state <= copPkg::finish;
          end
        end
        copPkg::finish: begin
          result <= copPkg::busWordT'(shifted);
          state  <= copPkg::idle;
        end
        default: begin
          state <= copPkg::idle;
        end
      endcase
    end
  end

  // Accumulator, seeded with the sign-extended bias on start
  always_ff @(posedge clk) begin
    if (startAccepted) begin
      acc <= copPkg::accT'(bias);
    end else if (state == copPkg::accumulate) begin
      acc <= acc + copPkg::accT'(product);
    end
  end

endmodule

/* logic/readBack.sv */
// Registered bus read path returning an operand register, the status word or the result
`timescale 1ns/1ps

module readBack (
  input  logic             clk,
  input  logic             rst,
  input  logic             read,
  input  copPkg::addrT     address,
  input  copPkg::regFileT  regFile,
  input  logic             busy,
  input  logic             done,
  input  copPkg::busWordT  result,
  output copPkg::busWordT  readData,
  output logic             readValid
);

  copPkg::addrT    offset;
  logic [6:0]      regIdx;
  logic            isReg;
  copPkg::dataT    regWord;
  copPkg::busWordT readWord;
  logic            doneFlag;
  logic            busyQ;

  // Word index inside the register window
  assign offset  = address - copPkg::firstRegAddr;
  assign regIdx  = offset[8:2];
  assign isReg   = (address >= copPkg::firstRegAddr) && (offset[1:0] == 2'b00)
                   && (regIdx < copPkg::regCount);
  assign regWord = regFile[regIdx];

  always_comb begin
    if (isReg) begin
      readWord = copPkg::busWordT'(regWord);
    end else if (address == copPkg::statusAddr) begin
      // Done also shows in the cycle it fires
      readWord = {30'd0, doneFlag | done, busy};
    end else if (address == copPkg::resultAddr) begin
      readWord = result;
    end else begin
      readWord = '0;
    end
  end

  // Sticky done, dropped when the next run raises busy
  always_ff @(posedge clk) begin
    if (rst) begin
      doneFlag  <= 1'b0;
      busyQ     <= 1'b0;
      readValid <= 1'b0;
    end else begin
      busyQ     <= busy;
      readValid <= read;
      if (done) begin
        doneFlag <= 1'b1;
      end else if (busy && !busyQ) begin
        doneFlag <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      readData <= readWord;
    end
  end

endmodule

/* logic/dotProductCop.sv */
// Top level of the dot-product coprocessor, bus in, read data and run status out
`timescale 1ns/1ps

module dotProductCop (
  input  logic             clk,
  input  logic             rst,
  input  copPkg::busReqT   busReq,
  output copPkg::busWordT  readData,
  output logic             readValid,
  output logic             busy,
  output logic             done
);

  copPkg::enablesT enableRegister;
  logic            enableStart;
  copPkg::regFileT regFile;
  copPkg::busWordT result;

  decoEscrituraRegistros decoder (
    .write          (busReq.write),
    .address        (busReq.address),
    .enableRegister (enableRegister),
    .enableStart    (enableStart)
  );

  registerBank bank (
    .clk            (clk),
    .rst            (rst),
    .enableRegister (enableRegister),
    .data           (busReq.data),
    .regFile        (regFile)
  );

  dotProductEngine engine (
    .clk         (clk),
    .rst         (rst),
    .enableStart (enableStart),
    .regFile     (regFile),
    .busy        (busy),
    .done        (done),
    .result      (result)
  );

  // Read path sees the engine levels for the status word
  readBack reader (
    .clk       (clk),
    .rst       (rst),
    .read      (busReq.read),
    .address   (busReq.address),
    .regFile   (regFile),
    .busy      (busy),
    .done      (done),
    .result    (result),
    .readData  (readData),
    .readValid (readValid)
  );

endmodule

/* testbench/dotProductModel.svh */
// Random operand source and golden dot-product model, included inside the testbench module
`ifndef DOT_PRODUCT_MODEL_SVH
`define DOT_PRODUCT_MODEL_SVH

  // LCG state, fixed seed so every run sees the same operands
  logic [31:0] lcgState = 32'd33387;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Upper half of the state, the low bits of an LCG repeat too soon
  function automatic copPkg::dataT randomWord();
    logic [31:0] value;
    value = nextRandom();
    return copPkg::dataT'(value[31:16]);
  endfunction

  // Bias plus the ten products, shifted right with sign, low 32 bits kept
  function automatic logic [31:0] goldenResult(input copPkg::dataT regs [copPkg::regCount]);
    longint      sum;
    int unsigned shift;
    sum = longint'(regs[copPkg::biasIdx]);
    for (int i = 0; i < copPkg::pairCount; i++) begin
      sum = sum + longint'(regs[i]) * longint'(regs[i + copPkg::pairCount]);
    end
    // Only the low 5 bits of the shift word count
    shift = 32'(regs[copPkg::shiftIdx][4:0]);
    sum   = sum >>> shift;
    return 32'(sum);
  endfunction

`endif

/* testbench/dotProductCopTb.sv */
// Self-checking testbench for the dot-product coprocessor, bus stimulus with assertion checks
`timescale 1ns/1ps

module dotProductCopTb;

  localparam int clkPeriod  = 40;
  localparam int runCount   = 30;
  localparam int busyCycles = copPkg::pairCount;
  localparam int doneAge    = busyCycles + 1;
  localparam int doneWait   = 20;
  // Upper bound on bus operations and done waits, each allowed 20 cycles
  localparam int opCount    = 150 + (runCount + 1) * 30;
  localparam longint watchdogLimit = longint'(opCount) * 20 * clkPeriod + 100 * clkPeriod;

  // Off-map addresses, unaligned ones around the last slot included
  localparam copPkg::addrT holeAddrs [8] = '{9'h000, 9'h008, 9'h00E, 9'h05E,
                                            9'h062, 9'h064, 9'h098, 9'h1FC};

  logic            clk;
  logic            rst;
  copPkg::busReqT  busReq;
  copPkg::busWordT readData;
  logic            readValid;
  logic            busy;
  logic            done;

  // Reference model state
  copPkg::dataT    shadow [copPkg::regCount];
  int              runAge;
  logic            modelDoneFlag;
  copPkg::busWordT expResult;
  copPkg::busWordT modelResult;
  logic            readPending;
  copPkg::busWordT expRead;
  logic            expBusy;
  logic            expDone;
  copPkg::enablesT expEnables;
  logic            expStart;

  int errorCount = 0;
  int runsDone   = 0;

  `include "dotProductModel.svh"

  dotProductCop UUT (
    .clk       (clk),
    .rst       (rst),
    .busReq    (busReq),
    .readData  (readData),
    .readValid (readValid),
    .busy      (busy),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  function automatic copPkg::addrT slotAddr(input int k);
    return copPkg::addrT'(copPkg::firstRegAddr + k * copPkg::regStride);
  endfunction

  function automatic copPkg::enablesT expectedEnables(input copPkg::busReqT req);
    copPkg::enablesT en;
    en = '0;
    for (int k = 0; k < copPkg::regCount; k++) begin
      en[k] = req.write && (req.address == slotAddr(k));
    end
    return en;
  endfunction

  function automatic copPkg::busWordT expectedReadWord(input copPkg::addrT address);
    copPkg::busWordT word;
    word = '0;
    for (int k = 0; k < copPkg::regCount; k++) begin
      if (address == slotAddr(k)) begin
        word = {{16{shadow[k][15]}}, shadow[k]};
      end
    end
    if (address == copPkg::statusAddr) begin
      word = {30'd0, modelDoneFlag | expDone, expBusy};
    end else if (address == copPkg::resultAddr) begin
      word = modelResult;
    end
    return word;
  endfunction

  assign expBusy    = (runAge >= 1) && (runAge <= busyCycles);
  assign expDone    = (runAge == doneAge);
  assign expEnables = expectedEnables(busReq);
  assign expStart   = busReq.write && (busReq.address == copPkg::startAddr);

  // runAge counts edges since the accepted start, zero when idle
  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < copPkg::regCount; k++) begin
        shadow[k] <= '0;
      end
      runAge        <= 0;
      modelDoneFlag <= 1'b0;
      expResult     <= '0;
      modelResult   <= '0;
      readPending   <= 1'b0;
      expRead       <= '0;
    end else begin
      for (int k = 0; k < copPkg::regCount; k++) begin
        if (busReq.write && busReq.address == slotAddr(k)) begin
          shadow[k] <= busReq.data;
        end
      end
      if (runAge == 0) begin
        if (expStart) begin
          runAge    <= 1;
          expResult <= goldenResult(shadow);
        end
      end else if (runAge == doneAge) begin
        runAge      <= 0;
        modelResult <= expResult;
      end else begin
        runAge <= runAge + 1;
      end
      if (runAge == doneAge) begin
        modelDoneFlag <= 1'b1;
      end else if (runAge == 1) begin
        modelDoneFlag <= 1'b0;
      end
      readPending <= busReq.read;
      if (busReq.read) begin
        expRead <= expectedReadWord(busReq.address);
      end
    end
  end

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] got);
    errorCount++;
    $display("MISMATCH %s expected %h got %h at %0t", name, expected, got, $time);
  endtask

  busyCheck: assert property (@(posedge clk) disable iff (rst) busy == expBusy)
    else reportMismatch("busy", 32'($sampled(expBusy)), 32'($sampled(busy)));
  doneCheck: assert property (@(posedge clk) disable iff (rst) done == expDone)
    else reportMismatch("done", 32'($sampled(expDone)), 32'($sampled(done)));
  validCheck: assert property (@(posedge clk) disable iff (rst) readValid == readPending)
    else reportMismatch("readValid", 32'($sampled(readPending)), 32'($sampled(readValid)));
  dataCheck: assert property (@(posedge clk) disable iff (rst)
                              readPending |-> readData == expRead)
    else reportMismatch("readData", $sampled(expRead), $sampled(readData));

  // Decoder checks on the top-level enable wires
  enableCheck: assert property (@(posedge clk) disable iff (rst)
                                UUT.enableRegister == expEnables)
    else reportMismatch("enableRegister", 32'($sampled(expEnables)),
                        32'($sampled(UUT.enableRegister)));
  startCheck: assert property (@(posedge clk) disable iff (rst) UUT.enableStart == expStart)
    else reportMismatch("enableStart", 32'($sampled(expStart)), 32'($sampled(UUT.enableStart)));
  oneHotCheck: assert property (@(posedge clk) disable iff (rst) $onehot0(UUT.enableRegister))
    else begin
      errorCount++;
      $display("Decoder raised more than one register enable at %0t", $time);
    end
  overlapCheck: assert property (@(posedge clk) disable iff (rst)
                                 !(UUT.enableStart && (UUT.enableRegister != '0)))
    else begin
      errorCount++;
      $display("Start enable and a register enable were high together at %0t", $time);
    end

  task automatic writeReg(input copPkg::addrT address, input copPkg::dataT value);
    @(negedge clk);
    busReq.write   = 1'b1;
    busReq.read    = 1'b0;
    busReq.address = address;
    busReq.data    = value;
    @(negedge clk);
    busReq.write = 1'b0;
  endtask

  task automatic readReg(input copPkg::addrT address);
    @(negedge clk);
    busReq.write   = 1'b0;
    busReq.read    = 1'b1;
    busReq.address = address;
    @(negedge clk);
    busReq.read = 1'b0;
  endtask

  task automatic startRun();
    writeReg(copPkg::startAddr, 16'sh0001);
  endtask

  task automatic waitDone();
    int waited;
    waited = 0;
    while (done !== 1'b1 && waited < doneWait) begin
      @(negedge clk);
      waited++;
    end
    if (done !== 1'b1) begin
      errorCount++;
      $display("No done pulse within %0d cycles of the start", doneWait);
    end
    // Result register loads on the edge after done
    @(negedge clk);
  endtask

  task automatic readAllSlots();
    for (int k = 0; k < copPkg::regCount; k++) begin
      readReg(slotAddr(k));
    end
  endtask

  // Runs 0 and 1 use the largest magnitudes to stress the 40-bit sum
  task automatic loadOperands(input int runIdx);
    copPkg::dataT value;
    for (int k = 0; k < 2 * copPkg::pairCount; k++) begin
      if (runIdx == 0) begin
        value = 16'sh8000;
      end else if (runIdx == 1) begin
        value = (k < copPkg::pairCount) ? 16'sh8000 : 16'sh7FFF;
      end else begin
        value = randomWord();
      end
      writeReg(slotAddr(k), value);
    end
    writeReg(slotAddr(copPkg::biasIdx), (runIdx == 1) ? 16'sh8000 : randomWord());
    if (runIdx == 0) begin
      writeReg(slotAddr(copPkg::shiftIdx), 16'sh0000);
    end else if (runIdx == 1) begin
      writeReg(slotAddr(copPkg::shiftIdx), 16'sh001F);
    end else begin
      writeReg(slotAddr(copPkg::shiftIdx), randomWord() & 16'sh001F);
    end
  endtask

  initial begin
    #(watchdogLimit);
    $display("Watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  initial begin
    busReq = '0;
    rst    = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Everything readable starts at zero
    readAllSlots();
    readReg(copPkg::statusAddr);
    readReg(copPkg::resultAddr);

    for (int k = 0; k < copPkg::regCount; k++) begin
      writeReg(slotAddr(k), randomWord());
    end
    readAllSlots();

    // Off-map writes, then a read of the start address
    foreach (holeAddrs[i]) begin
      writeReg(holeAddrs[i], randomWord());
    end
    readReg(copPkg::startAddr);
    startRun();
    waitDone();
    readAllSlots();

    foreach (holeAddrs[i]) begin
      readReg(holeAddrs[i]);
    end

    for (int r = 0; r < runCount; r++) begin
      loadOperands(r);
      readReg(copPkg::statusAddr);
      startRun();
      readReg(copPkg::statusAddr);
      waitDone();
      readReg(copPkg::statusAddr);
      readReg(copPkg::resultAddr);
      runsDone++;
    end

    // Second start lands while busy
    loadOperands(runCount);
    startRun();
    writeReg(copPkg::startAddr, 16'sh00A5);
    waitDone();
    readReg(copPkg::resultAddr);
    readReg(copPkg::statusAddr);

    repeat (3) @(negedge clk);
    $display("Closing report: %0d runs checked, %0d errors", runsDone, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+testbench
logic/copPkg.sv
logic/decoEscrituraRegistros.sv
logic/registerBank.sv
logic/dotProductEngine.sv
logic/readBack.sv
logic/dotProductCop.sv
testbench/dotProductCopTb.sv

/* Makefile */
# Verilator build and run of the dot-product coprocessor testbench

VERILATOR ?= verilator
TOP       ?= dotProductCopTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Everything OK

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard testbench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line appears in the simulation output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
